/* source/wb_pkg.sv */
// --------------------------------------------------
// Shared widths, opcodes and payload structs for the
// execute-to-writeback slice. Valid bits are not part
// of any struct and travel beside them
// --------------------------------------------------

`default_nettype none

package wb_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  localparam int data_w    = 32;
  localparam int addr_w    = 32;
  localparam int seq_w     = 8;
  localparam int reg_w     = 5;
  localparam int num_pipes = 2;

  // Execute operation codes
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_mul = 3'd5
  } exec_op_e;

  // --------------------------------------------------
  // Payload structs
  // --------------------------------------------------

  // Operation as handed over by issue
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [seq_w-1:0]  seq_num;
    exec_op_e          op;
    logic [reg_w-1:0]  waddr;
    logic              wen;
    logic [data_w-1:0] src_a;
    logic [data_w-1:0] src_b;
  } issue_t;

  // Pipe result towards writeback
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [seq_w-1:0]  seq_num;
    logic [reg_w-1:0]  waddr;
    logic [data_w-1:0] wdata;
    logic              wen;
  } x_wb_t;

  // For register file and scoreboard
  typedef struct packed {
    logic [seq_w-1:0]  seq_num;
    logic [reg_w-1:0]  waddr;
    logic [data_w-1:0] wdata;
    logic              wen;
  } complete_t;

  // Same as completion plus the pc
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [seq_w-1:0]  seq_num;
    logic [reg_w-1:0]  waddr;
    logic [data_w-1:0] wdata;
    logic              wen;
  } commit_t;

endpackage

`default_nettype wire

/* source/rr_arb.sv */
// --------------------------------------------------
// Round-robin arbiter, one grant per cycle.
// Search starts after the last granted requester.
// Pointer resets to requester 0
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rr_arb #(
  parameter int num_reqs = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [num_reqs-1:0] req,
  output logic [num_reqs-1:0] gnt
);

  localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

  // Highest priority requester for this cycle
  logic [ptr_w-1:0] ptr;
  logic [ptr_w-1:0] gnt_idx;
  logic             found;

  // --------------------------------------------------
  // Grant search
  // --------------------------------------------------

  always_comb begin
    gnt     = '0;
    gnt_idx = ptr;
    found   = 1'b0;
    for (int i = 0; i < num_reqs; i++) begin
      if (!found && req[(int'(ptr) + i) % num_reqs]) begin
        found                               = 1'b1;
        gnt[(int'(ptr) + i) % num_reqs]     = 1'b1;
        gnt_idx = ptr_w'((int'(ptr) + i) % num_reqs);
      end
    end
  end

  // Move past the winner, hold when idle
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (found) begin
      if (gnt_idx == ptr_w'(num_reqs - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= gnt_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/alu_pipe.sv */
// --------------------------------------------------
// One-stage ALU pipe: add, sub, and, or, xor.
// Result sits in one output register until taken.
// Any other opcode yields zero data
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module alu_pipe
  import wb_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  input  issue_t issue,
  input  logic   issue_val,
  output logic   issue_rdy,

  output x_wb_t  result,
  output logic   result_val,
  input  logic   result_rdy
);

  logic [data_w-1:0] alu_out;
  logic              issue_fire;

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------

  always_comb begin
    case (issue.op)
      op_add:  alu_out = issue.src_a + issue.src_b;
      op_sub:  alu_out = issue.src_a - issue.src_b;
      op_and:  alu_out = issue.src_a & issue.src_b;
      op_or:   alu_out = issue.src_a | issue.src_b;
      op_xor:  alu_out = issue.src_a ^ issue.src_b;
      default: alu_out = '0;
    endcase
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // Free slot, or the current result leaves this cycle
  assign issue_rdy  = !result_val || result_rdy;
  assign issue_fire = issue_val && issue_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_val <= 1'b0;
    end else if (issue_fire) begin
      result_val <= 1'b1;
    end else if (result_rdy) begin
      result_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      result.pc      <= issue.pc;
      result.seq_num <= issue.seq_num;
      result.waddr   <= issue.waddr;
      result.wdata   <= alu_out;
      result.wen     <= issue.wen;
    end
  end

endmodule

`default_nettype wire

/* source/mul_pipe.sv */
// --------------------------------------------------
// Two-stage multiplier pipe, low product word only.
// Stage one holds operands, stage two the product.
// Up to two operations in flight, kept in order
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mul_pipe
  import wb_pkg::*;
(
  input  logic   clk,
  input  logic   rst,

  input  issue_t issue,
  input  logic   issue_val,
  output logic   issue_rdy,

  output x_wb_t  result,
  output logic   result_val,
  input  logic   result_rdy
);

  // Stage one contents, opcode not needed here
  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [seq_w-1:0]  seq_num;
    logic [reg_w-1:0]  waddr;
    logic              wen;
    logic [data_w-1:0] src_a;
    logic [data_w-1:0] src_b;
  } mul_s1_t;

  mul_s1_t           s1_q;
  logic              s1_val;
  logic              s2_free;
  logic              s1_adv;
  logic              issue_fire;
  logic [data_w-1:0] prod_lo;

  // --------------------------------------------------
  // Stage handshakes
  // --------------------------------------------------

  assign s2_free    = !result_val || result_rdy;
  assign s1_adv     = s1_val && s2_free;
  assign issue_rdy  = !s1_val || s2_free;
  assign issue_fire = issue_val && issue_rdy;

  // Low word only, sized by the target
  assign prod_lo = s1_q.src_a * s1_q.src_b;

  // --------------------------------------------------
  // Stage one
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
    end else if (issue_fire) begin
      s1_val <= 1'b1;
    end else if (s1_adv) begin
      s1_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      s1_q.pc      <= issue.pc;
      s1_q.seq_num <= issue.seq_num;
      s1_q.waddr   <= issue.waddr;
      s1_q.wen     <= issue.wen;
      s1_q.src_a   <= issue.src_a;
      s1_q.src_b   <= issue.src_b;
    end
  end

  // --------------------------------------------------
  // Stage two
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      result_val <= 1'b0;
    end else if (s1_adv) begin
      result_val <= 1'b1;
    end else if (result_rdy) begin
      result_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_adv) begin
      result.pc      <= s1_q.pc;
      result.seq_num <= s1_q.seq_num;
      result.waddr   <= s1_q.waddr;
      result.wdata   <= prod_lo;
      result.wen     <= s1_q.wen;
    end
  end

endmodule

`default_nettype wire

/* source/writeback_unit.sv */
// --------------------------------------------------
// Writeback: picks one pipe result per cycle, round
// robin, and registers it. Ready to a pipe is its
// grant. Notices carry no back-pressure
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module writeback_unit
  import wb_pkg::*;
#(
  parameter int num_reqs = num_pipes
) (
  input  logic                clk,
  input  logic                rst,

  input  x_wb_t               x_res [num_reqs],
  input  logic [num_reqs-1:0] x_val,
  output logic [num_reqs-1:0] x_rdy,

  output complete_t           complete,
  output logic                complete_val,
  output commit_t             commit,
  output logic                commit_val
);

  logic [num_reqs-1:0] gnt;
  x_wb_t               x_masked [num_reqs];
  x_wb_t               sel;
  logic                sel_val;

  x_wb_t               wb_q;
  logic                wb_val;

  // --------------------------------------------------
  // Pipe selection
  // --------------------------------------------------

  rr_arb #(
    .num_reqs (num_reqs)
  ) arb (
    .clk (clk),
    .rst (rst),
    .req (x_val),
    .gnt (gnt)
  );

  // Losing pipes see ready low and hold their result
  assign x_rdy = gnt;

  // Zero every result except the granted one
  for (genvar i = 0; i < num_reqs; i++) begin : g_mask
    assign x_masked[i] = x_wb_t'(x_res[i] & {$bits(x_wb_t){gnt[i]}});
  end

  always_comb begin
    sel = '0;
    for (int i = 0; i < num_reqs; i++) begin
      sel = x_wb_t'(sel | x_masked[i]);
    end
  end

  // Grant only goes to a valid requester
  assign sel_val = |gnt;

  // --------------------------------------------------
  // Writeback register
  // --------------------------------------------------

  // Empty cycles load zeros, so wen drops with valid
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_val   <= 1'b0;
      wb_q.wen <= 1'b0;
    end else begin
      wb_val <= sel_val;
      wb_q   <= sel;
    end
  end

  // --------------------------------------------------
  // Notices
  // --------------------------------------------------

  assign complete = '{
    seq_num: wb_q.seq_num,
    waddr:   wb_q.waddr,
    wdata:   wb_q.wdata,
    wen:     wb_q.wen
  };
  assign complete_val = wb_val;

  assign commit = '{
    pc:      wb_q.pc,
    seq_num: wb_q.seq_num,
    waddr:   wb_q.waddr,
    wdata:   wb_q.wdata,
    wen:     wb_q.wen
  };
  assign commit_val = wb_val;

endmodule

`default_nettype wire

/* source/exec_wb_top.sv */
// --------------------------------------------------
// Execute and writeback slice. Pipe 0 is the ALU,
// pipe 1 the multiplier. Uncontended latency from
// issue to completion is 2 and 3 cycles
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_wb_top
  import wb_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  issue_t    alu_issue,
  input  logic      alu_issue_val,
  output logic      alu_issue_rdy,

  input  issue_t    mul_issue,
  input  logic      mul_issue_val,
  output logic      mul_issue_rdy,

  output complete_t complete,
  output logic      complete_val,
  output commit_t   commit,
  output logic      commit_val
);

  // Pipe results in arbiter order
  x_wb_t                x_res [num_pipes];
  logic [num_pipes-1:0] x_val;
  logic [num_pipes-1:0] x_rdy;

  // --------------------------------------------------
  // Execute pipes
  // --------------------------------------------------

  alu_pipe alu (
    .clk        (clk),
    .rst        (rst),
    .issue      (alu_issue),
    .issue_val  (alu_issue_val),
    .issue_rdy  (alu_issue_rdy),
    .result     (x_res[0]),
    .result_val (x_val[0]),
    .result_rdy (x_rdy[0])
  );

  mul_pipe mul (
    .clk        (clk),
    .rst        (rst),
    .issue      (mul_issue),
    .issue_val  (mul_issue_val),
    .issue_rdy  (mul_issue_rdy),
    .result     (x_res[1]),
    .result_val (x_val[1]),
    .result_rdy (x_rdy[1])
  );

  // --------------------------------------------------
  // Writeback
  // --------------------------------------------------

  writeback_unit #(
    .num_reqs (num_pipes)
  ) wb (
    .clk          (clk),
    .rst          (rst),
    .x_res        (x_res),
    .x_val        (x_val),
    .x_rdy        (x_rdy),
    .complete     (complete),
    .complete_val (complete_val),
    .commit       (commit),
    .commit_val   (commit_val)
  );

endmodule

`default_nettype wire

/* tb/exec_wb_chk.sv */
// --------------------------------------------------
// Protocol checks bound into exec_wb_top. Issue ports
// must hold val and payload until ready
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_wb_chk
  import wb_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input issue_t    alu_issue,
  input logic      alu_issue_val,
  input logic      alu_issue_rdy,
  input issue_t    mul_issue,
  input logic      mul_issue_val,
  input logic      mul_issue_rdy,
  input complete_t complete,
  input logic      complete_val,
  input commit_t   commit,
  input logic      commit_val
);

  // Failed checks so far
  int err_count = 0;

  a_val_pair: assert property (@(posedge clk) disable iff (rst)
    complete_val == commit_val)
    else begin
      err_count++;
      $error("complete_val and commit_val disagree");
    end

  a_fields_match: assert property (@(posedge clk) disable iff (rst)
    complete_val |-> commit.seq_num == complete.seq_num &&
      commit.waddr == complete.waddr && commit.wdata == complete.wdata &&
      commit.wen == complete.wen)
    else begin
      err_count++;
      $error("commit fields differ from completion fields");
    end

  a_alu_hold: assert property (@(posedge clk) disable iff (rst)
    alu_issue_val && !alu_issue_rdy |=> alu_issue_val && $stable(alu_issue))
    else begin
      err_count++;
      $error("ALU issue dropped or changed before transfer");
    end

  a_mul_hold: assert property (@(posedge clk) disable iff (rst)
    mul_issue_val && !mul_issue_rdy |=> mul_issue_val && $stable(mul_issue))
    else begin
      err_count++;
      $error("multiplier issue dropped or changed before transfer");
    end

endmodule

bind exec_wb_top exec_wb_chk chk (
  .clk           (clk),
  .rst           (rst),
  .alu_issue     (alu_issue),
  .alu_issue_val (alu_issue_val),
  .alu_issue_rdy (alu_issue_rdy),
  .mul_issue     (mul_issue),
  .mul_issue_val (mul_issue_val),
  .mul_issue_rdy (mul_issue_rdy),
  .complete      (complete),
  .complete_val  (complete_val),
  .commit        (commit),
  .commit_val    (commit_val)
);

`default_nettype wire

/* tb/exec_wb_tb.sv */
// --------------------------------------------------
// Testbench for the execute-to-writeback slice.
// Per-pipe queues hold expected results; concurrent
// assertions compare each completion with a queue head
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module exec_wb_tb
  import wb_pkg::*;
();

  localparam int num_ops     = 400;
  localparam int stim_limit  = 20000;
  localparam int drain_limit = 200;

  logic      clk;
  logic      rst;
  issue_t    alu_issue;
  logic      alu_issue_val;
  logic      alu_issue_rdy;
  issue_t    mul_issue;
  logic      mul_issue_val;
  logic      mul_issue_rdy;
  complete_t complete;
  logic      complete_val;
  commit_t   commit;
  logic      commit_val;

  // Expected results per pipe, oldest first
  x_wb_t alu_q[$];
  x_wb_t mul_q[$];
  x_wb_t alu_head;
  x_wb_t mul_head;
  int    alu_cnt;
  int    mul_cnt;

  logic alu_fire;
  logic mul_fire;
  logic alu_hit;
  logic mul_hit;
  logic alu_lone;
  logic mul_lone;

  exec_wb_top uut (
    .clk           (clk),
    .rst           (rst),
    .alu_issue     (alu_issue),
    .alu_issue_val (alu_issue_val),
    .alu_issue_rdy (alu_issue_rdy),
    .mul_issue     (mul_issue),
    .mul_issue_val (mul_issue_val),
    .mul_issue_rdy (mul_issue_rdy),
    .complete      (complete),
    .complete_val  (complete_val),
    .commit        (commit),
    .commit_val    (commit_val)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic fail_value(input string msg);
    fail_run($sformatf("ERR at %0d ns: %s", $time, msg));
  endtask

  function automatic x_wb_t predict_result(input issue_t op);
    x_wb_t             res;
    logic [2*data_w-1:0] prod;
    prod          = (2*data_w)'(op.src_a) * (2*data_w)'(op.src_b);
    res.pc        = op.pc;
    res.seq_num   = op.seq_num;
    res.waddr     = op.waddr;
    res.wen       = op.wen;
    case (op.op)
      op_add:  res.wdata = op.src_a + op.src_b;
      op_sub:  res.wdata = op.src_a - op.src_b;
      op_and:  res.wdata = op.src_a & op.src_b;
      op_or:   res.wdata = op.src_a | op.src_b;
      op_xor:  res.wdata = op.src_a ^ op.src_b;
      op_mul:  res.wdata = prod[data_w-1:0];
      default: res.wdata = '0;
    endcase
    return res;
  endfunction

  // Small operands now and then, for easy products
  function automatic logic [data_w-1:0] random_operand();
    if ($urandom_range(3, 0) == 0) begin
      return data_w'($urandom_range(15, 0));
    end
    return data_w'($urandom);
  endfunction

  function automatic issue_t make_issue(input logic to_mul, input logic [seq_w-1:0] seq);
    issue_t op;
    op.pc      = addr_w'($urandom);
    op.seq_num = seq;
    op.op      = to_mul ? op_mul : exec_op_e'(3'($urandom_range(4, 0)));
    op.waddr   = reg_w'($urandom);
    op.wen     = 1'($urandom);
    op.src_a   = random_operand();
    op.src_b   = random_operand();
    return op;
  endfunction

  // Mode 0 saturates, 1 is random, 2 leaves gaps for lone ops
  function automatic logic issue_this_cycle(input int mode);
    if (mode == 0) begin
      return 1'b1;
    end else if (mode == 1) begin
      return 1'($urandom_range(1, 0));
    end
    return $urandom_range(7, 0) == 0;
  endfunction

  // --------------------------------------------------
  // Clock and reference model
  // --------------------------------------------------

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin : ref_model
    if (rst) begin
      alu_q.delete();
      mul_q.delete();
    end else begin
      if (complete_val && alu_hit) begin
        void'(alu_q.pop_front());
      end else if (complete_val && mul_hit) begin
        void'(mul_q.pop_front());
      end
      if (alu_fire) begin
        alu_q.push_back(predict_result(alu_issue));
      end
      if (mul_fire) begin
        mul_q.push_back(predict_result(mul_issue));
      end
    end
    alu_cnt  <= alu_q.size();
    mul_cnt  <= mul_q.size();
    alu_head <= '0;
    mul_head <= '0;
    if (alu_q.size() != 0) begin
      alu_head <= alu_q[0];
    end
    if (mul_q.size() != 0) begin
      mul_head <= mul_q[0];
    end
  end

  always @(posedge clk) begin : chk_monitor
    if (uut.chk.err_count != 0) begin
      fail_run("Protocol checker inside the DUT flagged a violation");
    end
  end

  assign alu_fire = alu_issue_val && alu_issue_rdy;
  assign mul_fire = mul_issue_val && mul_issue_rdy;
  assign alu_hit  = alu_cnt != 0 && complete.seq_num == alu_head.seq_num;
  assign mul_hit  = mul_cnt != 0 && complete.seq_num == mul_head.seq_num;
  assign alu_lone = alu_fire && alu_cnt == 0 && mul_cnt == 0;
  assign mul_lone = mul_fire && alu_cnt == 0 && mul_cnt == 0;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_reset_state: assert property (@(posedge clk)
    rst |=> !complete_val && !commit_val && alu_issue_rdy && mul_issue_rdy)
    else fail_value("outputs not in reset state after reset");

  a_known_head: assert property (@(posedge clk) disable iff (rst)
    complete_val |-> alu_hit || mul_hit)
    else fail_value("completion matches no queue head, lost or duplicated");

  a_alu_result: assert property (@(posedge clk) disable iff (rst)
    complete_val && alu_hit |-> complete.wdata == alu_head.wdata &&
      complete.waddr == alu_head.waddr && complete.wen == alu_head.wen)
    else fail_value("ALU completion differs from expected");

  a_mul_result: assert property (@(posedge clk) disable iff (rst)
    complete_val && mul_hit && !alu_hit |-> complete.wdata == mul_head.wdata &&
      complete.waddr == mul_head.waddr && complete.wen == mul_head.wen)
    else fail_value("multiplier completion differs from expected");

  a_commit_pc: assert property (@(posedge clk) disable iff (rst)
    commit_val |-> commit.pc == (alu_hit ? alu_head.pc : mul_head.pc) &&
      commit.wen == (alu_hit ? alu_head.wen : mul_head.wen))
    else fail_value("commit pc or wen differs from issued op");

  a_alu_latency: assert property (@(posedge clk) disable iff (rst)
    $past(alu_lone, 2) |-> complete_val && complete.seq_num == $past(alu_issue.seq_num, 2))
    else fail_value("lone ALU op did not complete after 2 cycles");

  // An ALU op accepted one cycle later would contend for writeback
  a_mul_latency: assert property (@(posedge clk) disable iff (rst)
    $past(mul_lone, 3) && !$past(alu_fire, 2) |->
      complete_val && complete.seq_num == $past(mul_issue.seq_num, 3))
    else fail_value("lone multiplier op did not complete after 3 cycles");

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin : stimulus
    int               presented;
    int               cycles;
    int               waited;
    int               mode;
    logic [seq_w-1:0] next_seq;
    void'($urandom(32'ha0155aad));
    rst           <= 1'b1;
    alu_issue     <= '0;
    alu_issue_val <= 1'b0;
    mul_issue     <= '0;
    mul_issue_val <= 1'b0;
    presented = 0;
    next_seq  = '0;
    mode      = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    for (cycles = 0; cycles < stim_limit; cycles++) begin
      @(posedge clk);
      if (presented == num_ops && !alu_issue_val && !mul_issue_val) begin
        break;
      end
      if (cycles % 32 == 0) begin
        mode = $urandom_range(2, 0);
      end
      // New payload only once the held one has transferred
      if (!alu_issue_val || alu_issue_rdy) begin
        if (presented < num_ops && issue_this_cycle(mode)) begin
          alu_issue     <= make_issue(1'b0, next_seq);
          alu_issue_val <= 1'b1;
          next_seq++;
          presented++;
        end else begin
          alu_issue_val <= 1'b0;
        end
      end
      if (!mul_issue_val || mul_issue_rdy) begin
        if (presented < num_ops && issue_this_cycle(mode)) begin
          mul_issue     <= make_issue(1'b1, next_seq);
          mul_issue_val <= 1'b1;
          next_seq++;
          presented++;
        end else begin
          mul_issue_val <= 1'b0;
        end
      end
    end

    waited = 0;
    while (waited < drain_limit && (alu_cnt != 0 || mul_cnt != 0)) begin
      @(posedge clk);
      waited++;
    end
    if (presented != num_ops || alu_issue_val || mul_issue_val ||
        alu_cnt != 0 || mul_cnt != 0) begin
      fail_run("Timeout: operations were still outstanding at the end of the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
source/wb_pkg.sv
source/rr_arb.sv
source/alu_pipe.sv
source/mul_pipe.sv
source/writeback_unit.sv
source/exec_wb_top.sv
tb/exec_wb_chk.sv
tb/exec_wb_tb.sv

/* Makefile */
# Verilator build and run of the execute-to-writeback testbench
TOP := exec_wb_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
